// ==== sim.f ====
logic/mac_ctrl_pkg.sv
logic/mac_stat_pkg.sv
logic/link_ctrl_fsm.sv
logic/traffic_accum.sv
logic/error_counters.sv
logic/mac_link_top.sv
bench/tb_clk_gen.sv
bench/tb_mac_link.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_mac_link
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := CHECKS FAILED
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_mac_link.sv ====
// Testbench for mac_link_top with random stimulus, reference model, checks and summary

`timescale 1ns/1ps

module tb_mac_link
    import mac_ctrl_pkg::*;
    import mac_stat_pkg::*;
();

    localparam int CNT_W           = 32;
    localparam int ERR_W           = 8;
    localparam int SEED            = 17149;
    localparam int CLK_PERIOD_NS   = 8;
    localparam int TRAFFIC_CYCLES  = 500;
    localparam int ERROR_CYCLES    = 600;
    localparam int RESET_TRAFFIC   = 40;
    // Directed phases plus their random waits stay well below this
    localparam int DIRECTED_CYCLES = 120;
    localparam int TOTAL_CYCLES    = TRAFFIC_CYCLES + ERROR_CYCLES + RESET_TRAFFIC
                                     + DIRECTED_CYCLES;
    localparam int MARGIN_CYCLES   = 200;
    localparam int RX_STAT_W       = $bits(rx_stat_t);
    localparam int TX_STAT_W       = $bits(tx_stat_t);

    // Field order rx_enable, tx_enable, tx_send_lfi, tx_send_rfi
    localparam mac_ctl_t CTL_OFF   = 4'b0000;
    localparam mac_ctl_t CTL_FAULT = 4'b1011;
    localparam mac_ctl_t CTL_UP    = 4'b1100;

    logic             gt_txusrclk2;
    logic             gen_reset;
    logic             tb_reset;
    logic             usr_rx_reset_w;
    logic             stat_rx_aligned;
    rx_stat_t         rx_stat;
    tx_stat_t         tx_stat;
    rx_err_t          rx_err;
    mac_ctl_t         mac_ctl;
    logic [CNT_W-1:0] dut_tot [8];
    logic [ERR_W-1:0] err_count [NUM_ERR_KINDS];

    // Reference model state
    logic [CNT_W-1:0] exp_tot [8];
    logic [ERR_W-1:0] exp_err [NUM_ERR_KINDS];
    int               edge_cnt;

    string total_name [8] = '{"rx_total_bytes", "rx_good_bytes", "rx_good_packets",
                              "rx_total_packets", "tx_total_bytes", "tx_good_bytes",
                              "tx_good_packets", "tx_total_packets"};
    int    err_pct [NUM_ERR_KINDS];
    string cur_test;
    int    test_errs;
    int    total_errs;
    int    checks;
    int    tests_run;
    int    tests_failed;

    tb_clk_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (3)
    ) clk_gen_i (
        .clk (gt_txusrclk2),
        .rst (gen_reset)
    );

    assign usr_rx_reset_w = gen_reset | tb_reset;

    mac_link_top #(
        .CNT_W (CNT_W),
        .ERR_W (ERR_W)
    ) dut_i (
        .gt_txusrclk2     (gt_txusrclk2),
        .usr_rx_reset_w   (usr_rx_reset_w),
        .stat_rx_aligned  (stat_rx_aligned),
        .rx_stat          (rx_stat),
        .tx_stat          (tx_stat),
        .rx_err           (rx_err),
        .mac_ctl          (mac_ctl),
        .rx_total_bytes   (dut_tot[0]),
        .rx_good_bytes    (dut_tot[1]),
        .rx_good_packets  (dut_tot[2]),
        .rx_total_packets (dut_tot[3]),
        .tx_total_bytes   (dut_tot[4]),
        .tx_good_bytes    (dut_tot[5]),
        .tx_good_packets  (dut_tot[6]),
        .tx_total_packets (dut_tot[7]),
        .err_count        (err_count)
    );

    // Model samples the same inputs as the DUT on each rising edge
    always @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            for (int i = 0; i < 8; i++) begin
                exp_tot[i] <= '0;
            end
            for (int k = 0; k < NUM_ERR_KINDS; k++) begin
                exp_err[k] <= '0;
            end
            edge_cnt <= 0;
        end else begin
            exp_tot[0] <= exp_tot[0] + CNT_W'(rx_stat.total_bytes);
            exp_tot[1] <= exp_tot[1] + CNT_W'(rx_stat.good_bytes);
            exp_tot[2] <= exp_tot[2] + CNT_W'(rx_stat.good_packets);
            exp_tot[3] <= exp_tot[3] + CNT_W'(rx_stat.total_packets);
            exp_tot[4] <= exp_tot[4] + CNT_W'(tx_stat.total_bytes);
            exp_tot[5] <= exp_tot[5] + CNT_W'(tx_stat.good_bytes);
            exp_tot[6] <= exp_tot[6] + CNT_W'(tx_stat.good_packets);
            exp_tot[7] <= exp_tot[7] + CNT_W'(tx_stat.total_packets);
            // A flag field counts once per cycle whatever its value
            if (rx_err.aligned_err != '0) begin
                exp_err[ERR_ALIGN] <= exp_err[ERR_ALIGN] + ERR_W'(1);
            end
            if (rx_err.bad_code != '0) begin
                exp_err[ERR_CODE] <= exp_err[ERR_CODE] + ERR_W'(1);
            end
            if (rx_err.bad_fcs != '0) begin
                exp_err[ERR_FCS] <= exp_err[ERR_FCS] + ERR_W'(1);
            end
            if (rx_err.bad_preamble != '0) begin
                exp_err[ERR_PREAMBLE] <= exp_err[ERR_PREAMBLE] + ERR_W'(1);
            end
            if (rx_err.bad_sfd != '0) begin
                exp_err[ERR_SFD] <= exp_err[ERR_SFD] + ERR_W'(1);
            end
            edge_cnt <= edge_cnt + 1;
        end
    end

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s", cur_test);
        end else begin
            $display("FAIL %s with %0d errors", cur_test, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
    endtask

    task automatic expect_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_counters(input string tag);
        err_kind_e kind;
        for (int i = 0; i < 8; i++) begin
            expect_eq({tag, " ", total_name[i]}, 64'(exp_tot[i]), 64'(dut_tot[i]));
        end
        for (int k = 0; k < NUM_ERR_KINDS; k++) begin
            kind = err_kind_e'(k);
            expect_eq({tag, " ", kind.name()}, 64'(exp_err[k]), 64'(err_count[k]));
        end
    endtask

    task automatic expect_all_zero(input string tag);
        expect_eq({tag, " mac_ctl"}, 64'(CTL_OFF), 64'(mac_ctl));
        for (int i = 0; i < 8; i++) begin
            expect_eq({tag, " ", total_name[i]}, 64'(0), 64'(dut_tot[i]));
        end
        for (int k = 0; k < NUM_ERR_KINDS; k++) begin
            expect_eq($sformatf("%s err_count[%0d]", tag, k), 64'(0), 64'(err_count[k]));
        end
    endtask

    // Waits from a falling edge until the falling edge after rising edge k
    task automatic at_edge(input int k);
        while (edge_cnt < k) @(negedge gt_txusrclk2);
    endtask

    task automatic expect_ctl_span(input int first, input int last, input mac_ctl_t exp);
        for (int k = first; k <= last; k++) begin
            at_edge(k);
            expect_eq($sformatf("mac_ctl after edge %0d", k), 64'(exp), 64'(mac_ctl));
        end
    endtask

    function automatic int flag_value(input int pct, input int max_val);
        if (int'($urandom_range(99, 0)) < pct) begin
            return int'($urandom_range(max_val, 1));
        end else begin
            return 0;
        end
    endfunction

    function automatic rx_err_t random_errors();
        rx_err_t e;
        e.aligned_err  = 1'(flag_value(err_pct[ERR_ALIGN], 1));
        e.bad_code     = 3'(flag_value(err_pct[ERR_CODE], 7));
        e.bad_fcs      = 3'(flag_value(err_pct[ERR_FCS], 7));
        e.bad_preamble = 1'(flag_value(err_pct[ERR_PREAMBLE], 1));
        e.bad_sfd      = 1'(flag_value(err_pct[ERR_SFD], 1));
        return e;
    endfunction

    task automatic drive_random_traffic();
        rx_stat <= RX_STAT_W'($urandom);
        tx_stat <= TX_STAT_W'($urandom);
        rx_err  <= random_errors();
    endtask

    // Alignment comes up at a random edge n
    task automatic run_bring_up();
        int n;
        n = 4 + int'($urandom_range(7, 0));
        expect_ctl_span(1, 2, CTL_OFF);
        expect_ctl_span(3, n - 2, CTL_FAULT);
        @(posedge gt_txusrclk2);
        stat_rx_aligned <= 1'b1;
        @(negedge gt_txusrclk2);
        expect_ctl_span(n - 1, n + 1, CTL_FAULT);
        expect_ctl_span(n + 2, n + 4, CTL_UP);
    endtask

    initial begin : watchdog
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
        $display("TIMEOUT: run did not finish within %0d cycles",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        int m;
        void'($urandom(SEED));
        tb_reset        = 1'b0;
        stat_rx_aligned = 1'b0;
        rx_stat         = '0;
        tx_stat         = '0;
        rx_err          = '0;
        total_errs      = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failed    = 0;

        start_test("reset_state");
        @(posedge gt_txusrclk2);
        @(negedge gt_txusrclk2);
        while (usr_rx_reset_w) begin
            expect_all_zero("in reset");
            @(negedge gt_txusrclk2);
        end
        at_edge(1);
        expect_all_zero("edge 1");
        finish_test();

        start_test("bring_up");
        run_bring_up();
        finish_test();

        start_test("alignment_loss");
        m = edge_cnt + 2 + int'($urandom_range(5, 0));
        expect_ctl_span(edge_cnt, m - 2, CTL_UP);
        @(posedge gt_txusrclk2);
        stat_rx_aligned <= 1'b0;
        @(negedge gt_txusrclk2);
        expect_ctl_span(m - 1, m + 1, CTL_UP);
        // Receiver drops for a single cycle before faults resume
        expect_ctl_span(m + 2, m + 2, CTL_OFF);
        expect_ctl_span(m + 3, m + 5, CTL_FAULT);
        finish_test();

        start_test("random_traffic");
        for (int c = 0; c < TRAFFIC_CYCLES; c++) begin
            @(posedge gt_txusrclk2);
            rx_stat <= RX_STAT_W'($urandom);
            tx_stat <= TX_STAT_W'($urandom);
            @(negedge gt_txusrclk2);
            if ($urandom_range(49, 0) == 0) check_counters("mid-run");
        end
        @(posedge gt_txusrclk2);
        rx_stat <= '0;
        tx_stat <= '0;
        @(negedge gt_txusrclk2);
        check_counters("final");
        finish_test();

        start_test("random_errors");
        // At least half the cycles per kind so that 8-bit counts wrap
        for (int k = 0; k < NUM_ERR_KINDS; k++) begin
            err_pct[k] = int'($urandom_range(95, 50));
        end
        for (int c = 0; c < ERROR_CYCLES; c++) begin
            @(posedge gt_txusrclk2);
            rx_err <= random_errors();
            @(negedge gt_txusrclk2);
            if ($urandom_range(59, 0) == 0) check_counters("mid-run");
        end
        @(posedge gt_txusrclk2);
        rx_err <= '0;
        @(negedge gt_txusrclk2);
        check_counters("final");
        finish_test();

        start_test("reset_mid_traffic");
        for (int c = 0; c < RESET_TRAFFIC; c++) begin
            @(posedge gt_txusrclk2);
            drive_random_traffic();
            @(negedge gt_txusrclk2);
        end
        check_counters("before reset");
        @(posedge gt_txusrclk2);
        tb_reset <= 1'b1;
        drive_random_traffic();
        @(negedge gt_txusrclk2);
        repeat (3) begin
            @(posedge gt_txusrclk2);
            drive_random_traffic();
            @(negedge gt_txusrclk2);
            expect_all_zero("in reset");
        end
        @(posedge gt_txusrclk2);
        tb_reset <= 1'b0;
        rx_stat  <= '0;
        tx_stat  <= '0;
        rx_err   <= '0;
        @(negedge gt_txusrclk2);
        expect_all_zero("after reset");
        run_bring_up();
        check_counters("after bring-up");
        finish_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/tb_clk_gen.sv ====
// Testbench clock source and power-on reset generator

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset spans the first few rising edges, released on an edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== logic/mac_link_top.sv ====
// Top level joining the link bring-up FSM, traffic accumulators and error counters

`timescale 1ns/1ps

module mac_link_top
    import mac_ctrl_pkg::*;
    import mac_stat_pkg::*;
#(
    parameter int CNT_W = 32,
    parameter int ERR_W = 16
) (
    input  logic             gt_txusrclk2,
    input  logic             usr_rx_reset_w,
    input  logic             stat_rx_aligned,
    input  rx_stat_t         rx_stat,
    input  tx_stat_t         tx_stat,
    input  rx_err_t          rx_err,
    output mac_ctl_t         mac_ctl,
    output logic [CNT_W-1:0] rx_total_bytes,
    output logic [CNT_W-1:0] rx_good_bytes,
    output logic [CNT_W-1:0] rx_good_packets,
    output logic [CNT_W-1:0] rx_total_packets,
    output logic [CNT_W-1:0] tx_total_bytes,
    output logic [CNT_W-1:0] tx_good_bytes,
    output logic [CNT_W-1:0] tx_good_packets,
    output logic [CNT_W-1:0] tx_total_packets,
    output logic [ERR_W-1:0] err_count [NUM_ERR_KINDS]
);

    link_ctrl_fsm link_ctrl_fsm_i (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .mac_ctl         (mac_ctl)
    );

    // Statistics run regardless of link state
    traffic_accum #(
        .CNT_W (CNT_W)
    ) traffic_accum_i (
        .gt_txusrclk2     (gt_txusrclk2),
        .usr_rx_reset_w   (usr_rx_reset_w),
        .rx_stat          (rx_stat),
        .tx_stat          (tx_stat),
        .rx_total_bytes   (rx_total_bytes),
        .rx_good_bytes    (rx_good_bytes),
        .rx_good_packets  (rx_good_packets),
        .rx_total_packets (rx_total_packets),
        .tx_total_bytes   (tx_total_bytes),
        .tx_good_bytes    (tx_good_bytes),
        .tx_good_packets  (tx_good_packets),
        .tx_total_packets (tx_total_packets)
    );

    error_counters #(
        .ERR_W (ERR_W)
    ) error_counters_i (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .rx_err         (rx_err),
        .err_count      (err_count)
    );

endmodule

// ==== logic/error_counters.sv ====
// Per-kind RX error event counters, one count per cycle with the flag set

`timescale 1ns/1ps

module error_counters
    import mac_stat_pkg::*;
#(
    parameter int ERR_W = 16
) (
    input  logic             gt_txusrclk2,
    input  logic             usr_rx_reset_w,
    input  rx_err_t          rx_err,
    output logic [ERR_W-1:0] err_count [NUM_ERR_KINDS]
);

    logic [NUM_ERR_KINDS-1:0] err_evt;

    // Any nonzero field counts as a single event
    always_comb begin
        err_evt[ERR_ALIGN]    = |rx_err.aligned_err;
        err_evt[ERR_CODE]     = |rx_err.bad_code;
        err_evt[ERR_FCS]      = |rx_err.bad_fcs;
        err_evt[ERR_PREAMBLE] = |rx_err.bad_preamble;
        err_evt[ERR_SFD]      = |rx_err.bad_sfd;
    end

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            for (int i = 0; i < NUM_ERR_KINDS; i++) begin
                err_count[i] <= '0;
            end
        end else begin
            // Free running, wraps at the counter width
            for (int i = 0; i < NUM_ERR_KINDS; i++) begin
                if (err_evt[i]) begin
                    err_count[i] <= err_count[i] + ERR_W'(1);
                end
            end
        end
    end

    // Counts are clear on the cycle after any reset cycle
    for (genvar g = 0; g < NUM_ERR_KINDS; g++) begin : g_rst_chk
        a_rst_clear: assert property (
            @(posedge gt_txusrclk2)
            $past(usr_rx_reset_w) |-> err_count[g] == '0
        ) else $error("error counter %0d not cleared by reset", g);
    end

endmodule

// ==== logic/traffic_accum.sv ====
// RX and TX packet and byte accumulators fed by the per-cycle MAC increments

`timescale 1ns/1ps

module traffic_accum
    import mac_stat_pkg::*;
#(
    parameter int CNT_W = 32
) (
    input  logic             gt_txusrclk2,
    input  logic             usr_rx_reset_w,
    input  rx_stat_t         rx_stat,
    input  tx_stat_t         tx_stat,
    output logic [CNT_W-1:0] rx_total_bytes,
    output logic [CNT_W-1:0] rx_good_bytes,
    output logic [CNT_W-1:0] rx_good_packets,
    output logic [CNT_W-1:0] rx_total_packets,
    output logic [CNT_W-1:0] tx_total_bytes,
    output logic [CNT_W-1:0] tx_good_bytes,
    output logic [CNT_W-1:0] tx_good_packets,
    output logic [CNT_W-1:0] tx_total_packets
);

    localparam int NUM_ACC = 8;

    logic [CNT_W-1:0] inc [NUM_ACC];
    logic [CNT_W-1:0] acc [NUM_ACC];
    // One extra bit holds the carry out of each add
    logic [CNT_W:0]   sum [NUM_ACC];

    // Slots 0..3 are RX, 4..7 are TX
    always_comb begin
        inc[0] = CNT_W'(rx_stat.total_bytes);
        inc[1] = CNT_W'(rx_stat.good_bytes);
        inc[2] = CNT_W'(rx_stat.good_packets);
        inc[3] = CNT_W'(rx_stat.total_packets);
        inc[4] = CNT_W'(tx_stat.total_bytes);
        inc[5] = CNT_W'(tx_stat.good_bytes);
        inc[6] = CNT_W'(tx_stat.good_packets);
        inc[7] = CNT_W'(tx_stat.total_packets);
    end

    always_comb begin
        for (int i = 0; i < NUM_ACC; i++) begin
            sum[i] = {1'b0, acc[i]} + {1'b0, inc[i]};
        end
    end

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            for (int i = 0; i < NUM_ACC; i++) begin
                acc[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ACC; i++) begin
                acc[i] <= sum[i][CNT_W-1:0];
            end
        end
    end

    assign rx_total_bytes   = acc[0];
    assign rx_good_bytes    = acc[1];
    assign rx_good_packets  = acc[2];
    assign rx_total_packets = acc[3];
    assign tx_total_bytes   = acc[4];
    assign tx_good_bytes    = acc[5];
    assign tx_good_packets  = acc[6];
    assign tx_total_packets = acc[7];

    // A count falls back to zero only by wrapping past the top
    for (genvar g = 0; g < NUM_ACC; g++) begin : g_wrap_chk
        a_no_drop: assert property (
            @(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
            (!$past(usr_rx_reset_w) && $past(acc[g]) != '0 && acc[g] == '0)
                |-> $past(sum[g][CNT_W])
        ) else $error("accumulator %0d dropped to zero without wrapping", g);
    end

endmodule

// ==== logic/link_ctrl_fsm.sv ====
// Link bring-up FSM driving the MAC enable and fault-indication controls

`timescale 1ns/1ps

module link_ctrl_fsm
    import mac_ctrl_pkg::*;
(
    input  logic     gt_txusrclk2,
    input  logic     usr_rx_reset_w,
    input  logic     stat_rx_aligned,
    output mac_ctl_t mac_ctl
);

    link_state_e state;
    logic        reset_done;
    logic        aligned_q;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            state      <= LINK_IDLE;
            reset_done <= 1'b0;
            aligned_q  <= 1'b0;
            mac_ctl    <= '0;
        end else begin
            // One cycle after reset release the machine may leave idle
            reset_done <= 1'b1;
            aligned_q  <= stat_rx_aligned;
            case (state)
                LINK_IDLE: begin
                    mac_ctl.rx_enable   <= 1'b0;
                    mac_ctl.tx_enable   <= 1'b0;
                    mac_ctl.tx_send_lfi <= 1'b0;
                    mac_ctl.tx_send_rfi <= 1'b0;
                    if (reset_done) begin
                        state <= LINK_GT_LOCKED;
                    end
                end
                LINK_GT_LOCKED: begin
                    // Receiver on, transmitter signals faults until aligned
                    mac_ctl.rx_enable   <= 1'b1;
                    mac_ctl.tx_enable   <= 1'b0;
                    mac_ctl.tx_send_lfi <= 1'b1;
                    mac_ctl.tx_send_rfi <= 1'b1;
                    state               <= LINK_WAIT_ALIGNED;
                end
                LINK_WAIT_ALIGNED: begin
                    if (aligned_q) begin
                        state <= LINK_UP;
                    end
                end
                LINK_UP: begin
                    mac_ctl.tx_enable   <= 1'b1;
                    mac_ctl.tx_send_lfi <= 1'b0;
                    mac_ctl.tx_send_rfi <= 1'b0;
                    // Lost alignment, restart the whole sequence
                    if (!aligned_q) begin
                        state <= LINK_IDLE;
                    end
                end
                default: begin
                    state <= LINK_IDLE;
                end
            endcase
        end
    end

    // Never transmit data while still sending a local fault
    a_tx_no_lfi: assert property (
        @(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        !(mac_ctl.tx_enable && mac_ctl.tx_send_lfi)
    ) else $error("tx_enable and tx_send_lfi both set");

    // Transmit path only runs with the receiver enabled
    a_tx_needs_rx: assert property (
        @(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        mac_ctl.tx_enable |-> mac_ctl.rx_enable
    ) else $error("tx_enable set without rx_enable");

endmodule

// ==== logic/mac_stat_pkg.sv ====
// Per-cycle RX/TX statistic increments, RX error flags and error counter indices

package mac_stat_pkg;

    // RX increments, as reported by the MAC every cycle
    typedef struct packed {
        logic [6:0]  total_bytes;
        logic [13:0] good_bytes;
        logic        good_packets;
        logic [2:0]  total_packets;
    } rx_stat_t;

    // TX increments, same meaning with narrower fields
    typedef struct packed {
        logic [5:0]  total_bytes;
        logic [13:0] good_bytes;
        logic        good_packets;
        logic        total_packets;
    } tx_stat_t;

    // RX error flags, multi-bit ones are per-lane-group counts
    typedef struct packed {
        logic       aligned_err;
        logic [2:0] bad_code;
        logic [2:0] bad_fcs;
        logic       bad_preamble;
        logic       bad_sfd;
    } rx_err_t;

    // Index into the error counter array
    typedef enum logic [2:0] {
        ERR_ALIGN    = 3'd0,
        ERR_CODE     = 3'd1,
        ERR_FCS      = 3'd2,
        ERR_PREAMBLE = 3'd3,
        ERR_SFD      = 3'd4
    } err_kind_e;

    parameter int NUM_ERR_KINDS = 5;

endpackage

// ==== logic/mac_ctrl_pkg.sv ====
// Link bring-up state encoding and the control bundle driven to the MAC

package mac_ctrl_pkg;

    // Bring-up sequence, shared by the RX and TX control paths
    typedef enum logic [1:0] {
        LINK_IDLE         = 2'd0,
        LINK_GT_LOCKED    = 2'd1,
        LINK_WAIT_ALIGNED = 2'd2,
        LINK_UP           = 2'd3
    } link_state_e;

    // Control inputs of the MAC core
    typedef struct packed {
        logic rx_enable;
        logic tx_enable;
        // Local fault indication
        logic tx_send_lfi;
        // Remote fault indication
        logic tx_send_rfi;
    } mac_ctl_t;

endpackage
